// File: hdl/mult_pkg.sv
package mult_pkg;

    // block buffer geometry
    localparam int LOG_DEPTH = 6;
    localparam int DEPTH = 1 << LOG_DEPTH;

    // operand and product widths
    localparam int OPERAND_W = 16;
    localparam int PRODUCT_W = 2 * OPERAND_W;

    // register stages between operands and product
    localparam int MULT_STAGES = 2;
    // flush counter width, wide enough to count MULT_STAGES
    localparam int FLUSH_W = $clog2(MULT_STAGES) + 1;

    // index into the block buffer
    typedef logic [LOG_DEPTH-1:0] addr_t;

    // one operand pair as presented at the input
    typedef struct packed {
        logic [OPERAND_W-1:0] a;
        logic [OPERAND_W-1:0] b;
    } operand_pair_t;

    // unsigned product
    typedef logic [PRODUCT_W-1:0] product_t;

    // write request into the buffer
    typedef struct packed {
        logic     en;
        addr_t    addr;
        product_t data;
    } mem_wr_t;

    // read request into the buffer
    typedef struct packed {
        logic  en;
        addr_t addr;
    } mem_rd_t;

    // side info that follows a buffer read
    typedef struct packed {
        logic last;
    } read_tag_t;

endpackage

// File: hdl/stage_delay.sv
`timescale 1ns/1ps

module stage_delay #(
    parameter type payload_t = logic,
    parameter int  STAGES = 1
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    input  payload_t in_payload,
    output logic     out_valid,
    output payload_t out_payload
);

    // one valid bit and one payload per stage
    logic [STAGES-1:0] valid_q;
    payload_t          payload_q [STAGES];

    // valid chain, cleared on reset
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else begin
            valid_q[0] <= in_valid;
            for (int i = 1; i < STAGES; i++) begin
                valid_q[i] <= valid_q[i-1];
            end
        end
    end

    // payload shifts every cycle
    always_ff @(posedge clk) begin
        payload_q[0] <= in_payload;
        for (int i = 1; i < STAGES; i++) begin
            payload_q[i] <= payload_q[i-1];
        end
    end

    assign out_valid = valid_q[STAGES-1];
    assign out_payload = payload_q[STAGES-1];

endmodule

// File: hdl/mult_pipe.sv
`timescale 1ns/1ps

module mult_pipe (
    input  logic                    clk,
    input  mult_pkg::operand_pair_t operands,
    output mult_pkg::product_t      product
);
    import mult_pkg::*;

    // first stage holds the raw multiply
    product_t mult_q;

    // 16x16 unsigned
    // operands widened to the product width before the multiply
    always_ff @(posedge clk) begin
        mult_q <= product_t'(operands.a) * product_t'(operands.b);
    end

    // second stage lines up with the delayed write index
    always_ff @(posedge clk) begin
        product <= mult_q;
    end

endmodule

// File: hdl/product_ram.sv
`timescale 1ns/1ps

module product_ram (
    input  logic               clk,
    input  mult_pkg::mem_wr_t  wr,
    input  mult_pkg::mem_rd_t  rd,
    output mult_pkg::product_t rd_data
);
    import mult_pkg::*;

    // one block of products
    product_t mem [DEPTH];

    // write port
    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // registered read, one cycle latency
    // output holds between reads
    always_ff @(posedge clk) begin
        if (rd.en) begin
            rd_data <= mem[rd.addr];
        end
    end

endmodule

// File: hdl/mult_ctrl.sv
`timescale 1ns/1ps

module mult_ctrl (
    input  logic                clk,
    input  logic                rst,
    input  logic                op_valid,
    input  logic                read_req,
    output logic                rdy,
    output logic                full,
    output logic                accept,
    output mult_pkg::addr_t     wr_index,
    output mult_pkg::mem_rd_t   rd_req,
    output mult_pkg::read_tag_t rd_tag
);
    import mult_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE  = 3'd0,
        ST_FILL  = 3'd1,
        ST_FLUSH = 3'd2,
        ST_FULL  = 3'd3,
        ST_DRAIN = 3'd4
    } state_t;

    localparam addr_t LAST_INDEX = addr_t'(DEPTH - 1);
    localparam logic [FLUSH_W-1:0] FLUSH_LAST = FLUSH_W'(MULT_STAGES - 1);

    state_t             state;
    addr_t              rd_index;
    logic [FLUSH_W-1:0] flush_cnt;
    logic               last_accept;
    logic               draining;

    // operand taken this cycle
    assign accept = op_valid && rdy;
    // final pair of the block
    assign last_accept = accept && (wr_index == LAST_INDEX);
    assign draining = (state == ST_DRAIN);

    assign full = (state == ST_FULL);

    // one read per drain cycle, addresses in order
    always_comb begin
        rd_req.en = draining;
        rd_req.addr = rd_index;
        rd_tag.last = draining && (rd_index == LAST_INDEX);
    end

    // ready level
    // drops after the 64th accept, comes back one cycle into idle
    always_ff @(posedge clk) begin
        if (rst) begin
            rdy <= 1'b0;
        end else if (last_accept) begin
            rdy <= 1'b0;
        end else if (state == ST_IDLE) begin
            rdy <= 1'b1;
        end
    end

    // write index
    // wraps back to 0 on the 64th accept, so the next block starts clean
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_index <= '0;
        end else if (accept) begin
            wr_index <= wr_index + 1'b1;
        end
    end

    // main fsm with flush and read counters
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
            rd_index <= '0;
            flush_cnt <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (accept) begin
                        state <= ST_FILL;
                    end
                end
                ST_FILL: begin
                    if (last_accept) begin
                        state <= ST_FLUSH;
                        flush_cnt <= '0;
                    end
                end
                ST_FLUSH: begin
                    // let the last product pass the pipeline
                    flush_cnt <= flush_cnt + 1'b1;
                    if (flush_cnt == FLUSH_LAST) begin
                        state <= ST_FULL;
                    end
                end
                ST_FULL: begin
                    rd_index <= '0;
                    // read_req only counts here
                    if (read_req) begin
                        state <= ST_DRAIN;
                    end
                end
                ST_DRAIN: begin
                    rd_index <= rd_index + 1'b1;
                    if (rd_index == LAST_INDEX) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

// File: hdl/block_mult_top.sv
`timescale 1ns/1ps

module block_mult_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    op_valid,
    input  mult_pkg::operand_pair_t operands,
    input  logic                    read_req,
    output logic                    rdy,
    output logic                    full,
    output logic                    out_valid,
    output mult_pkg::product_t      out_data,
    output logic                    out_last
);
    import mult_pkg::*;

    // control outputs
    logic      accept;
    addr_t     wr_index;
    mem_rd_t   rd_req;
    read_tag_t rd_tag;

    // write side after the pipeline delay
    logic      wr_valid;
    addr_t     wr_addr;
    product_t  product;
    mem_wr_t   wr_req;

    // tag beside the read data
    read_tag_t out_tag;

    mult_ctrl u_ctrl (
        .clk      (clk),
        .rst      (rst),
        .op_valid (op_valid),
        .read_req (read_req),
        .rdy      (rdy),
        .full     (full),
        .accept   (accept),
        .wr_index (wr_index),
        .rd_req   (rd_req),
        .rd_tag   (rd_tag)
    );

    // multiplies every cycle; accept decides what lands
    mult_pipe u_pipe (
        .clk      (clk),
        .operands (operands),
        .product  (product)
    );

    // write strobe and index follow the product
    stage_delay #(
        .payload_t (addr_t),
        .STAGES    (MULT_STAGES)
    ) u_wr_delay (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (accept),
        .in_payload  (wr_index),
        .out_valid   (wr_valid),
        .out_payload (wr_addr)
    );

    assign wr_req = '{en: wr_valid, addr: wr_addr, data: product};

    product_ram u_ram (
        .clk     (clk),
        .wr      (wr_req),
        .rd      (rd_req),
        .rd_data (out_data)
    );

    // covers the one-cycle read latency
    stage_delay #(
        .payload_t (read_tag_t),
        .STAGES    (1)
    ) u_rd_delay (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (rd_req.en),
        .in_payload  (rd_tag),
        .out_valid   (out_valid),
        .out_payload (out_tag)
    );

    assign out_last = out_tag.last;

endmodule

// File: verif/clk_rst_gen.sv
`timescale 1ns/1ps

module clk_rst_gen #(
    parameter int PERIOD = 20,
    parameter int RESET_CYCLES = 16
) (
    output logic clk,
    output logic rst
);

    // free running clock
    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // reset held for a fixed number of rising edges
    // released on an edge, like any other driven input
    initial begin
        rst <= 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

// File: verif/block_mult_tb.sv
`timescale 1ns/1ps

module block_mult_tb;
    import mult_pkg::*;

    localparam int NUM_ROWS = 5;
    localparam int FILL_LIMIT = 1000;
    localparam int WAIT_LIMIT = 40;
    // top level latencies
    localparam int FULL_LATENCY = 3;
    localparam int READ_LATENCY = 2;

    // one block of stimulus
    typedef struct {
        int         corners;
        logic [7:0] gap_mask;
        int         read_delay;
        int         extra_pulses;
    } block_row_t;

    logic          clk;
    logic          rst;
    logic          op_valid;
    operand_pair_t operands;
    logic          read_req;
    logic          rdy;
    logic          full;
    logic          out_valid;
    product_t      out_data;
    logic          out_last;

    block_row_t    rows [NUM_ROWS];
    // scoreboard holds one product per accepted index
    product_t      expected [DEPTH];
    logic [31:0]   lfsr_state;

    clk_rst_gen #(
        .PERIOD       (20),
        .RESET_CYCLES (16)
    ) u_clk_rst (
        .clk (clk),
        .rst (rst)
    );

    block_mult_top u_dut (
        .clk       (clk),
        .rst       (rst),
        .op_valid  (op_valid),
        .operands  (operands),
        .read_req  (read_req),
        .rdy       (rdy),
        .full      (full),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_last  (out_last)
    );

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // shift and add model of the unsigned multiply
    function automatic product_t shift_add_product(input operand_pair_t pair);
        product_t acc;
        product_t addend;
        acc = '0;
        addend = product_t'(pair.a);
        for (int i = 0; i < OPERAND_W; i++) begin
            if (pair.b[i]) begin
                acc = acc + addend;
            end
            addend = addend << 1;
        end
        return acc;
    endfunction

    // one lfsr step per bit
    task automatic draw_operand(output logic [OPERAND_W-1:0] value);
        value = '0;
        for (int i = 0; i < OPERAND_W; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[OPERAND_W-2:0], lfsr_state[0]};
        end
    endtask

    // corner pairs first and random pairs after
    task automatic make_pair(input int corners, input int index, output operand_pair_t pair);
        logic [OPERAND_W-1:0] x;
        logic [OPERAND_W-1:0] y;
        draw_operand(x);
        draw_operand(y);
        pair.a = x;
        pair.b = y;
        if (index < corners) begin
            case (index)
                0: begin
                    pair.a = '0;
                    pair.b = '0;
                end
                1: begin
                    pair.a = '1;
                    pair.b = '1;
                end
                2: begin
                    pair.a = OPERAND_W'(1);
                end
                default: begin
                    pair.b = '0;
                end
            endcase
        end
    endtask

    // corners, gap mask, read delay, stray pulses
    task automatic load_table();
        rows[0] = '{4, 8'hff, 0, 0};
        rows[1] = '{2, 8'ha6, 5, 3};
        rows[2] = '{0, 8'h01, 40, 12};
        rows[3] = '{3, 8'hef, 1, 1};
        rows[4] = '{4, 8'h81, 12, 12};
    endtask

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("sim failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_product(input string what, input product_t actual,
                                 input product_t exp_val);
        if (actual !== exp_val) begin
            stop_run($sformatf("[FAIL] %0t ns: %s is %08h, expected %08h",
                               $time, what, actual, exp_val));
        end
    endtask

    task automatic check_flag(input string what, input logic actual, input logic exp_val);
        if (actual !== exp_val) begin
            stop_run($sformatf("[FAIL] %0t ns: %s is %b, expected %b",
                               $time, what, actual, exp_val));
        end
    endtask

    task automatic check_cycles(input string what, input int actual, input int exp_val);
        if (actual != exp_val) begin
            stop_run($sformatf("[FAIL] %0t ns: %s is %0d, expected %0d",
                               $time, what, actual, exp_val));
        end
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while (rst !== 1'b0 && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (rst !== 1'b0) begin
            stop_run("timeout: reset was never released");
        end
    endtask

    task automatic wait_ready();
        int cycles;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (rdy !== 1'b1 && cycles < WAIT_LIMIT);
        if (rdy !== 1'b1) begin
            stop_run("timeout: rdy never rose after reset");
        end
    endtask

    // counted from the edge of the 64th accept
    task automatic wait_full(output int cycles);
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
            check_flag("rdy after the 64th accept", rdy, 1'b0);
        end while (full !== 1'b1 && cycles < WAIT_LIMIT);
        if (full !== 1'b1) begin
            stop_run("timeout: full never rose after the block was filled");
        end
    endtask

    // counted from the edge that samples read_req
    task automatic wait_out_valid(output int cycles);
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
            check_flag("full during drain", full, 1'b0);
        end while (out_valid !== 1'b1 && cycles < WAIT_LIMIT);
        if (out_valid !== 1'b1) begin
            stop_run("timeout: out_valid never rose after read_req");
        end
    endtask

    // fill, flush, hold and drain one block
    task automatic run_block(input int r);
        block_row_t    row;
        operand_pair_t pending;
        operand_pair_t junk;
        int            accepted;
        int            fill_cycles;
        int            cycles;
        logic [2:0]    gap_pos;
        row = rows[r];
        accepted = 0;
        fill_cycles = 0;
        gap_pos = '0;
        make_pair(row.corners, 0, pending);
        while (accepted < DEPTH) begin
            @(posedge clk);
            check_flag("rdy during fill", rdy, 1'b1);
            check_flag("full during fill", full, 1'b0);
            // accept seen on this edge
            if (op_valid && rdy) begin
                expected[accepted] = shift_add_product(operands);
                accepted++;
                if (accepted < DEPTH) begin
                    make_pair(row.corners, accepted, pending);
                end
            end
            if (accepted < DEPTH) begin
                op_valid <= row.gap_mask[gap_pos];
                operands <= pending;
                gap_pos = gap_pos + 3'd1;
            end else begin
                // stray pulses into the flush
                make_pair(0, 0, junk);
                op_valid <= (row.extra_pulses > 0);
                operands <= junk;
            end
            fill_cycles++;
            if (fill_cycles > FILL_LIMIT) begin
                stop_run($sformatf("timeout: block %0d took only %0d pairs", r, accepted));
            end
        end
        wait_full(cycles);
        check_cycles("cycles from last accept to full", cycles, FULL_LATENCY);
        // hold in full while op_valid pulses are ignored
        for (int j = 0; j < row.read_delay; j++) begin
            make_pair(0, 0, junk);
            op_valid <= (j < row.extra_pulses);
            operands <= junk;
            @(posedge clk);
            check_flag("full while waiting", full, 1'b1);
            check_flag("rdy while full", rdy, 1'b0);
            check_flag("out_valid while full", out_valid, 1'b0);
        end
        op_valid <= 1'b0;
        read_req <= 1'b1;
        @(posedge clk);
        check_flag("full when read_req is sampled", full, 1'b1);
        read_req <= 1'b0;
        wait_out_valid(cycles);
        check_cycles("cycles from read_req to first beat", cycles, READ_LATENCY);
        // 64 beats back to back in index order
        for (int i = 0; i < DEPTH; i++) begin
            if (i > 0) begin
                @(posedge clk);
            end
            check_flag("out_valid during drain", out_valid, 1'b1);
            check_product($sformatf("out_data[%0d] of block %0d", i, r),
                          out_data, expected[i]);
            check_flag("out_last", out_last, (i == DEPTH - 1));
            check_flag("rdy during drain", rdy, 1'b0);
        end
        @(posedge clk);
        check_flag("out_valid after last beat", out_valid, 1'b0);
        check_flag("out_last after last beat", out_last, 1'b0);
        check_flag("rdy after last beat", rdy, 1'b1);
    endtask

    initial begin
        op_valid <= 1'b0;
        operands <= '0;
        read_req <= 1'b0;
        lfsr_state = 32'h7a37291f;
        load_table();
        wait_reset_release();
        wait_ready();
        check_flag("full after reset", full, 1'b0);
        check_flag("out_valid after reset", out_valid, 1'b0);
        check_flag("out_last after reset", out_last, 1'b0);
        // read_req in idle has nothing to drain
        read_req <= 1'b1;
        @(posedge clk);
        read_req <= 1'b0;
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            check_flag("out_valid after read_req in idle", out_valid, 1'b0);
            check_flag("full after read_req in idle", full, 1'b0);
        end
        for (int r = 0; r < NUM_ROWS; r++) begin
            run_block(r);
        end
        $display("sim passed");
        $finish;
    end

endmodule

// File: vlog.f
hdl/mult_pkg.sv
hdl/stage_delay.sv
hdl/mult_pipe.sv
hdl/product_ram.sv
hdl/mult_ctrl.sv
hdl/block_mult_top.sv
verif/clk_rst_gen.sv
verif/block_mult_tb.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary -j 0
TOP       := block_mult_tb
FILELIST  := vlog.f
OBJ_DIR   := obj_dir

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# exit status of the simulator is the result
run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)
